// ==== rv_backend.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_ex_mem_if.sv
hdl/rv_alu.sv
hdl/rv_pipeline_ex_mem.sv
hdl/rv_data_memory.sv
hdl/rv_pipeline_mem_wb.sv
hdl/rv_backend.sv
dv/rv_backend_asserts.sv
dv/rv_backend_checker.sv
dv/rv_backend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the rv_backend testbench with Verilator and runs it.
# Exit status is 0 only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -j 0 \
    -f rv_backend.f --top-module rv_backend_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$build_dir/Vrv_backend_tb")
run_status=$?
echo "$output"

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// ==== dv/rv_backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_backend_tb;

    localparam int unsigned SEED         = 32'h82bf_67d1;
    localparam int          RESET_CYCLES = 8;
    localparam int          DRAIN_LIMIT  = 16;  // Cycles allowed for the pipeline to empty

    logic             clock;
    logic             reset;
    rv_pkg::inst_addr pc;
    rv_pkg::data_word op_a;
    rv_pkg::data_word op_b;
    rv_pkg::data_word store_data;
    rv_pkg::alu_op_e  alu_op;
    logic             mem_wr_enable;
    rv_pkg::reg_addr  reg_wr_addr;
    logic             reg_wr_enable;
    rv_pkg::wb_sel_e  wb_sel;
    logic             flush;
    logic             wb_enable;
    rv_pkg::reg_addr  wb_addr;
    rv_pkg::data_word wb_data;
    rv_pkg::inst_addr wb_pc;
    int               error_count;
    int               check_count;
    logic             checker_idle;

    rv_pkg::data_word written_addr[$];  // Byte addresses holding known data
    rv_pkg::inst_addr next_pc;
    int               expected_writes;  // Unflushed register writes of the current test
    int               error_base;
    int               check_base;
    int               tests_passed;
    int               tests_failed;
    int               assert_failures;

    rv_backend UUT (
        .i_clock (clock), .i_reset (reset), .i_pc (pc), .i_op_a (op_a), .i_op_b (op_b),
        .i_store_data (store_data), .i_alu_op (alu_op), .i_mem_wr_enable (mem_wr_enable),
        .i_reg_wr_addr (reg_wr_addr), .i_reg_wr_enable (reg_wr_enable), .i_wb_sel (wb_sel),
        .i_flush (flush), .o_wb_enable (wb_enable), .o_wb_addr (wb_addr),
        .o_wb_data (wb_data), .o_wb_pc (wb_pc)
    );

    rv_backend_checker u_checker (
        .i_clock (clock), .i_reset (reset), .i_pc (pc), .i_op_a (op_a), .i_op_b (op_b),
        .i_store_data (store_data), .i_alu_op (alu_op), .i_mem_wr_enable (mem_wr_enable),
        .i_reg_wr_addr (reg_wr_addr), .i_reg_wr_enable (reg_wr_enable), .i_wb_sel (wb_sel),
        .i_flush (flush), .i_wb_enable (wb_enable), .i_wb_addr (wb_addr),
        .i_wb_data (wb_data), .i_wb_pc (wb_pc), .o_error_count (error_count),
        .o_check_count (check_count), .o_idle (checker_idle)
    );

    always #2 clock = ~clock;  // 4 ns period

    function automatic rv_pkg::alu_op_e random_op();
        return rv_pkg::alu_op_e'(4'($urandom_range(9, 0)));
    endfunction

    function automatic rv_pkg::data_word random_address();
        return $urandom() & 32'hffff_fffc;  // Word aligned with random upper bits
    endfunction

    function automatic rv_pkg::data_word random_written();
        return written_addr[$urandom_range(written_addr.size() - 1, 0)];
    endfunction

    // Applies one operation on the falling edge and returns after it was sampled
    task automatic drive_op(input rv_pkg::alu_op_e op, input rv_pkg::data_word a,
                            input rv_pkg::data_word b, input rv_pkg::wb_sel_e sel,
                            input logic mem_we, input logic reg_we, input logic fl);
        pc            = next_pc;
        op_a          = a;
        op_b          = b;
        alu_op        = op;
        wb_sel        = sel;
        mem_wr_enable = mem_we;
        reg_wr_enable = reg_we;
        flush         = fl;
        store_data    = $urandom();
        reg_wr_addr   = rv_pkg::reg_addr'($urandom_range(31, 0));
        next_pc       = next_pc + 32'd4;
        if (reg_we && !fl && !reset) begin
            expected_writes++;
        end
        @(negedge clock);
    endtask

    task automatic issue_alu(input logic fl);
        drive_op(random_op(), $urandom(), $urandom(), rv_pkg::WB_ALU, 1'b0, 1'b1, fl);
    endtask

    task automatic issue_link();
        drive_op(random_op(), $urandom(), $urandom(), rv_pkg::WB_LINK, 1'b0, 1'b1, 1'b0);
    endtask

    // Address is formed as base plus offset through the adder
    task automatic issue_store(input rv_pkg::data_word addr, input logic fl);
        rv_pkg::data_word base;
        base = $urandom();
        drive_op(rv_pkg::ALU_ADD, base, addr - base, rv_pkg::WB_ALU, 1'b1, 1'b0, fl);
        if (!fl) begin
            written_addr.push_back(addr);
        end
    endtask

    task automatic issue_load(input rv_pkg::data_word addr);
        rv_pkg::data_word base;
        base = $urandom();
        drive_op(rv_pkg::ALU_ADD, base, addr - base, rv_pkg::WB_LOAD, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic start_test(input string name);
        u_checker.test_name = name;
        error_base          = error_count;
        check_base          = check_count;
        expected_writes     = 0;
    endtask

    task automatic finish_test(input string name);
        int cycles;
        int errors;
        int checked;
        mem_wr_enable = 1'b0;  // Bubbles while draining
        reg_wr_enable = 1'b0;
        flush         = 1'b0;
        cycles        = 0;
        while (!checker_idle && cycles < DRAIN_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        errors  = error_count - error_base;
        checked = check_count - check_base;
        if (!checker_idle) begin
            $display("Test %s: write-backs still pending after %0d cycles", name, DRAIN_LIMIT);
            errors++;
        end else if (checked != expected_writes) begin
            $display("Test %s: %0d write-backs seen but %0d register writes were issued",
                     name, checked, expected_writes);
            errors++;
        end
        if (errors == 0) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s (%0d problems)", name, errors);
        end
    endtask

    initial begin
        int               i;
        rv_pkg::data_word addr;
        clock         = 1'b0;
        reset         = 1'b1;
        pc            = '0;
        op_a          = '0;
        op_b          = '0;
        store_data    = '0;
        alu_op        = rv_pkg::ALU_ADD;
        mem_wr_enable = 1'b0;
        reg_wr_addr   = '0;
        reg_wr_enable = 1'b0;
        wb_sel        = rv_pkg::WB_ALU;
        flush         = 1'b0;
        tests_passed  = 0;
        tests_failed  = 0;
        void'($urandom(SEED));
        next_pc = random_address();

        start_test("reset");
        repeat (RESET_CYCLES) issue_alu(1'b0);  // Register writes requested during reset
        reset = 1'b0;
        repeat (4) issue_alu(1'b0);
        finish_test("reset");

        start_test("alu_random");
        repeat (200) issue_alu(1'b0);
        finish_test("alu_random");

        start_test("store_load");
        for (i = 0; i < 40; i++) begin
            addr = random_address();
            issue_store(addr, 1'b0);
            if ($urandom_range(1, 0) == 1) begin
                issue_load(addr);  // Same word right after the store
            end else begin
                issue_load(random_written());
            end
        end
        finish_test("store_load");

        start_test("link");
        repeat (40) issue_link();
        finish_test("link");

        start_test("flush");
        for (i = 0; i < 20; i++) begin
            issue_alu(1'b1);
            addr = random_written();
            issue_store(addr, 1'b1);
            issue_load(addr);  // Must still see the old word
        end
        finish_test("flush");

        start_test("stream");
        for (i = 0; i < 400; i++) begin
            case ($urandom_range(4, 0))
                0:       issue_alu(1'b0);
                1:       issue_store(random_address(), 1'b0);
                2:       issue_load(random_written());
                3:       issue_link();
                default: issue_alu(1'b1);
            endcase
        end
        finish_test("stream");

        assert_failures = UUT.u_ex_mem.u_asserts.failure_count;
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, assert_failures);
        if (tests_failed == 0 && assert_failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/rv_backend_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_backend_checker (
    input  logic             i_clock,
    input  logic             i_reset,
    input  rv_pkg::inst_addr i_pc,
    input  rv_pkg::data_word i_op_a,
    input  rv_pkg::data_word i_op_b,
    input  rv_pkg::data_word i_store_data,
    input  rv_pkg::alu_op_e  i_alu_op,
    input  logic             i_mem_wr_enable,
    input  rv_pkg::reg_addr  i_reg_wr_addr,
    input  logic             i_reg_wr_enable,
    input  rv_pkg::wb_sel_e  i_wb_sel,
    input  logic             i_flush,
    input  logic             i_wb_enable,    // Watched DUT outputs
    input  rv_pkg::reg_addr  i_wb_addr,
    input  rv_pkg::data_word i_wb_data,
    input  rv_pkg::inst_addr i_wb_pc,
    output int               o_error_count,
    output int               o_check_count,  // Write-backs compared
    output logic             o_idle          // No issued operation left to check
);

    localparam int               IDX_W = $clog2(`RV_DMEM_WORDS);
    localparam rv_pkg::data_word ONES  = '1;
    localparam rv_pkg::data_word SIGN  = rv_pkg::data_word'(1) << (`RV_DATA_WIDTH - 1);

    string            test_name = "none";  // Set by the testbench top
    int               errors    = 0;
    int               checks    = 0;
    rv_pkg::data_word shadow [`RV_DMEM_WORDS];  // Memory in program order

    // Index 0 is the operation in memory stage, index 1 the one in write-back
    logic             exp_valid [2] = '{1'b0, 1'b0};
    logic             exp_live  [2] = '{1'b0, 1'b0};  // Operation other than a bubble
    logic             exp_en    [2] = '{1'b0, 1'b0};
    rv_pkg::reg_addr  exp_addr  [2];
    rv_pkg::data_word exp_data  [2];
    rv_pkg::inst_addr exp_pc    [2];

    assign o_error_count = errors;
    assign o_check_count = checks;
    assign o_idle        = !exp_live[0] && !exp_live[1];

    function automatic rv_pkg::data_word alu_model(input rv_pkg::alu_op_e op,
                                                   input rv_pkg::data_word a,
                                                   input rv_pkg::data_word b);
        logic [4:0]       sh;
        rv_pkg::data_word fill;
        sh   = b[4:0];
        fill = a[`RV_DATA_WIDTH-1] ? ~(ONES >> sh) : '0;  // Upper bits for arithmetic shift
        case (op)
            rv_pkg::ALU_ADD:  return a + b;
            rv_pkg::ALU_SUB:  return a - b;
            rv_pkg::ALU_AND:  return a & b;
            rv_pkg::ALU_OR:   return a | b;
            rv_pkg::ALU_XOR:  return a ^ b;
            rv_pkg::ALU_SLL:  return a << sh;
            rv_pkg::ALU_SRL:  return a >> sh;
            rv_pkg::ALU_SRA:  return (a >> sh) | fill;
            rv_pkg::ALU_SLT:  return rv_pkg::data_word'((a ^ SIGN) < (b ^ SIGN));  // Bias trick
            rv_pkg::ALU_SLTU: return rv_pkg::data_word'(a < b);
            default:          return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string field, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR %s %s: expected %h, actual %h", test_name, field, expected, actual);
        errors++;
    endtask

    always @(posedge i_clock) begin
        rv_pkg::data_word value;
        logic [IDX_W-1:0] index;
        if (exp_valid[1]) begin
            if (i_wb_enable !== exp_en[1]) begin
                report_mismatch("wb_enable", 32'(exp_en[1]), 32'(i_wb_enable));
            end else if (exp_en[1]) begin
                checks++;
                if (i_wb_addr !== exp_addr[1]) begin
                    report_mismatch("wb_addr", 32'(exp_addr[1]), 32'(i_wb_addr));
                end
                if (i_wb_data !== exp_data[1]) begin
                    report_mismatch("wb_data", exp_data[1], i_wb_data);
                end
                if (i_wb_pc !== exp_pc[1]) begin
                    report_mismatch("wb_pc", exp_pc[1], i_wb_pc);
                end
            end
        end
        exp_valid[1] = exp_valid[0];  // Advance the two-deep model
        exp_live[1]  = exp_live[0];
        exp_en[1]    = exp_en[0];
        exp_addr[1]  = exp_addr[0];
        exp_data[1]  = exp_data[0];
        exp_pc[1]    = exp_pc[0];
        if (i_reset) begin
            exp_valid[0] = 1'b1;  // Reset empties both stages
            exp_live[0]  = 1'b0;
            exp_en[0]    = 1'b0;
            exp_valid[1] = 1'b1;
            exp_live[1]  = 1'b0;
            exp_en[1]    = 1'b0;
        end else begin
            value = (i_wb_sel == rv_pkg::WB_LINK) ? rv_pkg::data_word'(i_pc + 32'd4)
                                                  : alu_model(i_alu_op, i_op_a, i_op_b);
            index        = IDX_W'((value >> 2) % `RV_DMEM_WORDS);
            exp_valid[0] = 1'b1;
            exp_live[0]  = i_reg_wr_enable || i_mem_wr_enable;
            exp_en[0]    = i_reg_wr_enable && !i_flush;
            exp_addr[0]  = i_reg_wr_addr;
            exp_pc[0]    = i_pc;
            exp_data[0]  = (i_wb_sel == rv_pkg::WB_LOAD) ? shadow[index] : value;
            if (i_mem_wr_enable && !i_flush) begin
                shadow[index] = i_store_data;  // Read above sees the old word
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/rv_backend_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_backend_asserts (
    input logic            i_clock,
    input logic            i_reset,
    input logic            i_flush,          // Flush request at the EX/MEM input
    input logic            i_mem_wr_enable,  // Registered store request
    input logic            i_reg_wr_enable,  // Registered register write request
    input rv_pkg::wb_sel_e i_wb_sel
);

    int failure_count = 0;  // Read by the testbench top at the end of the run

    enables_low_after_reset: assert property (
        @(posedge i_clock) i_reset |=> (!i_mem_wr_enable && !i_reg_wr_enable)
    ) else begin
        $error("EX/MEM write enables not cleared by reset");
        failure_count++;
    end

    flushed_store_dropped: assert property (
        @(posedge i_clock) disable iff (i_reset) i_flush |=> !i_mem_wr_enable
    ) else begin
        $error("flushed operation reached memory with its store enabled");
        failure_count++;
    end

    // Encoding 3 is unused
    wb_sel_legal: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_wb_sel inside {rv_pkg::WB_ALU, rv_pkg::WB_LOAD, rv_pkg::WB_LINK}
    ) else begin
        $error("EX/MEM wb_sel holds an illegal encoding");
        failure_count++;
    end

endmodule

bind rv_pipeline_ex_mem rv_backend_asserts u_asserts (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_flush         (i_flush),
    .i_mem_wr_enable (o_stage.mem_wr_enable),
    .i_reg_wr_enable (o_stage.reg_wr_enable),
    .i_wb_sel        (o_stage.wb_sel)
);

`default_nettype wire

// ==== hdl/rv_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_backend (
    input  logic             i_clock,
    input  logic             i_reset,

    input  rv_pkg::inst_addr i_pc,
    input  rv_pkg::data_word i_op_a,
    input  rv_pkg::data_word i_op_b,
    input  rv_pkg::data_word i_store_data,     // Word for a store
    input  rv_pkg::alu_op_e  i_alu_op,
    input  logic             i_mem_wr_enable,
    input  rv_pkg::reg_addr  i_reg_wr_addr,
    input  logic             i_reg_wr_enable,
    input  rv_pkg::wb_sel_e  i_wb_sel,
    input  logic             i_flush,          // Cancel the operation in execute

    output logic             o_wb_enable,
    output rv_pkg::reg_addr  o_wb_addr,
    output rv_pkg::data_word o_wb_data,
    output rv_pkg::inst_addr o_wb_pc
);

    rv_pkg::data_word alu_result;
    rv_pkg::inst_addr alu_link;
    rv_pkg::data_word ex_value;    // Value carried into EX/MEM
    rv_pkg::data_word load_data;

    rv_ex_mem_if ex_mem_bus ();

    rv_alu u_alu (
        .i_op_a   (i_op_a),
        .i_op_b   (i_op_b),
        .i_alu_op (i_alu_op),
        .i_pc     (i_pc),
        .o_result (alu_result),
        .o_link   (alu_link)
    );

    // Jumps write back the link address instead of the ALU result
    assign ex_value = (i_wb_sel == rv_pkg::WB_LINK) ? rv_pkg::data_word'(alu_link)
                                                    : alu_result;

    rv_pipeline_ex_mem u_ex_mem (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_flush         (i_flush),
        .i_pc            (i_pc),
        .i_result        (ex_value),
        .i_store_data    (i_store_data),
        .i_mem_wr_enable (i_mem_wr_enable),
        .i_reg_wr_addr   (i_reg_wr_addr),
        .i_reg_wr_enable (i_reg_wr_enable),
        .i_wb_sel        (i_wb_sel),
        .o_stage         (ex_mem_bus.stage_out)
    );

    rv_data_memory u_dmem (
        .i_clock     (i_clock),
        .i_stage     (ex_mem_bus.mem_side),
        .o_load_data (load_data)
    );

    rv_pipeline_mem_wb u_mem_wb (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_stage     (ex_mem_bus.wb_side),
        .i_load_data (load_data),
        .o_wb_enable (o_wb_enable),
        .o_wb_addr   (o_wb_addr),
        .o_wb_data   (o_wb_data),
        .o_wb_pc     (o_wb_pc)
    );

endmodule

`default_nettype wire

// ==== hdl/rv_pipeline_mem_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline_mem_wb (
    input  logic             i_clock,
    input  logic             i_reset,
    rv_ex_mem_if.wb_side     i_stage,      // Operation in the memory stage
    input  rv_pkg::data_word i_load_data,  // Word read by the memory stage

    output logic             o_wb_enable,  // Register write request
    output rv_pkg::reg_addr  o_wb_addr,
    output rv_pkg::data_word o_wb_data,
    output rv_pkg::inst_addr o_wb_pc
);

    rv_pkg::data_word wb_value;  // Selected write-back data

    // Link already sits in result, so only loads need the memory word
    assign wb_value = (i_stage.wb_sel == rv_pkg::WB_LOAD) ? i_load_data : i_stage.result;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_wb_enable <= 1'b0;
        end else begin
            o_wb_enable <= i_stage.reg_wr_enable;
        end
    end

    always_ff @(posedge i_clock) begin
        o_wb_addr <= i_stage.reg_wr_addr;
        o_wb_data <= wb_value;
        o_wb_pc   <= i_stage.pc;  // Carried for tracing the retired operation
    end

endmodule

`default_nettype wire

// ==== hdl/rv_data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_data_memory (
    input  logic             i_clock,
    rv_ex_mem_if.mem_side    i_stage,      // Address, store data and write enable
    output rv_pkg::data_word o_load_data   // Word at the current address
);

    localparam int ADDR_BITS = $clog2(`RV_DMEM_WORDS);  // Word index width

    rv_pkg::data_word             mem [`RV_DMEM_WORDS];
    logic [ADDR_BITS-1:0]         word_index;

    // Byte address to word index wrapping at the memory depth
    assign word_index = i_stage.result[ADDR_BITS+1:2];

    always_ff @(posedge i_clock) begin
        if (i_stage.mem_wr_enable) begin
            mem[word_index] <= i_stage.store_data;  // Store lands at end of stage
        end
    end

    assign o_load_data = mem[word_index];  // Asynchronous read

endmodule

`default_nettype wire

// ==== hdl/rv_pipeline_ex_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline_ex_mem (
    input  logic               i_clock,
    input  logic               i_reset,
    input  logic               i_flush,          // Cancels the writes of this operation

    input  rv_pkg::inst_addr   i_pc,
    input  rv_pkg::data_word   i_result,         // ALU result or link address
    input  rv_pkg::data_word   i_store_data,
    input  logic               i_mem_wr_enable,  // Store request
    input  rv_pkg::reg_addr    i_reg_wr_addr,
    input  logic               i_reg_wr_enable,  // Register write request
    input  rv_pkg::wb_sel_e    i_wb_sel,

    rv_ex_mem_if.stage_out     o_stage           // Registered operation for memory stage
);

    logic keep;  // Operation survives flush

    assign keep = ~i_flush;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_stage.pc            <= '0;
            o_stage.result        <= '0;
            o_stage.store_data    <= '0;
            o_stage.mem_wr_enable <= 1'b0;
            o_stage.reg_wr_addr   <= '0;
            o_stage.reg_wr_enable <= 1'b0;
            o_stage.wb_sel        <= rv_pkg::WB_ALU;
        end else begin
            o_stage.pc            <= i_pc;
            o_stage.result        <= i_result;
            o_stage.store_data    <= i_store_data;
            o_stage.mem_wr_enable <= i_mem_wr_enable & keep;  // Flushed store is dropped
            o_stage.reg_wr_addr   <= i_reg_wr_addr;
            o_stage.reg_wr_enable <= i_reg_wr_enable & keep;
            o_stage.wb_sel        <= i_wb_sel;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_pkg::data_word i_op_a,    // First operand
    input  rv_pkg::data_word i_op_b,    // Second operand or shift amount
    input  rv_pkg::alu_op_e  i_alu_op,  // Operation select
    input  rv_pkg::inst_addr i_pc,      // Address of the operation
    output rv_pkg::data_word o_result,
    output rv_pkg::inst_addr o_link     // Return address for jumps
);

    logic [4:0] shamt;       // Shift amount
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = i_op_b[4:0];
    assign lt_signed   = $signed(i_op_a) < $signed(i_op_b);
    assign lt_unsigned = i_op_a < i_op_b;

    always_comb begin
        case (i_alu_op)
            rv_pkg::ALU_ADD: begin
                o_result = i_op_a + i_op_b;
            end
            rv_pkg::ALU_SUB: begin
                o_result = i_op_a - i_op_b;
            end
            rv_pkg::ALU_AND: begin
                o_result = i_op_a & i_op_b;
            end
            rv_pkg::ALU_OR: begin
                o_result = i_op_a | i_op_b;
            end
            rv_pkg::ALU_XOR: begin
                o_result = i_op_a ^ i_op_b;
            end
            rv_pkg::ALU_SLL: begin
                o_result = i_op_a << shamt;
            end
            rv_pkg::ALU_SRL: begin
                o_result = i_op_a >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                o_result = rv_pkg::data_word'($signed(i_op_a) >>> shamt);  // Sign fill
            end
            rv_pkg::ALU_SLT: begin
                o_result = rv_pkg::data_word'(lt_signed);
            end
            rv_pkg::ALU_SLTU: begin
                o_result = rv_pkg::data_word'(lt_unsigned);
            end
            default: begin
                o_result = '0;  // Unused encodings
            end
        endcase
    end

    // Link is always computed; the top level decides whether it is used
    assign o_link = i_pc + rv_pkg::inst_addr'(4);

endmodule

`default_nettype wire

// ==== hdl/rv_ex_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rv_ex_mem_if;

    rv_pkg::inst_addr pc;             // Address of the operation
    rv_pkg::data_word result;         // Result or link that also addresses memory
    rv_pkg::data_word store_data;     // Word to store
    logic             mem_wr_enable;  // Store request
    rv_pkg::reg_addr  reg_wr_addr;
    logic             reg_wr_enable;  // Register write request
    rv_pkg::wb_sel_e  wb_sel;

    modport stage_out (
        output pc, result, store_data, mem_wr_enable,
        output reg_wr_addr, reg_wr_enable, wb_sel
    );

    // Memory only sees the address and the store side
    modport mem_side (
        input result, store_data, mem_wr_enable
    );

    modport wb_side (
        input pc, result, reg_wr_addr, reg_wr_enable, wb_sel
    );

endinterface

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_PC_WIDTH-1:0]       inst_addr;  // Instruction address
    typedef logic [`RV_DATA_WIDTH-1:0]     data_word;  // Operand, result, memory word
    typedef logic [`RV_REG_ADDR_WIDTH-1:0] reg_addr;   // Destination register

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_LINK = 2'd2
    } wb_sel_e;

endpackage

`default_nettype wire

// ==== hdl/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath word width
`define RV_DATA_WIDTH 32

// Register index width for 32 architectural registers
`define RV_REG_ADDR_WIDTH 5

// Instruction address width
`define RV_PC_WIDTH 32

// Data memory depth in words
`define RV_DMEM_WORDS 64

`endif
